// File: logic/calc_pkg.sv
// Shared enums and key event struct used by the calculator RTL and its testbench
package calc_pkg;

    // Operator codes carried by an operator key
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    typedef enum logic [1:0] {
        KEY_DIGIT = 2'd0,
        KEY_OP    = 2'd1,
        KEY_EQUAL = 2'd2
    } key_kind_t;

    // One held key press, 9 bits
    typedef struct packed {
        key_kind_t  kind;
        logic [3:0] digit;
        op_t        op;
    } key_event_t;

    typedef enum logic [3:0] {
        WAIT_OP1      = 4'd0,
        MULT_OP1      = 4'd1,
        ADD_DIGIT_OP1 = 4'd2,
        WAIT_OP2      = 4'd3,
        MULT_OP2      = 4'd4,
        ADD_DIGIT_OP2 = 4'd5,
        SEND_COMPUTE  = 4'd6,
        WAIT_COMPUTE  = 4'd7,
        SHOW_RESULT   = 4'd8
    } ctrl_state_t;

endpackage

// File: logic/key_capture.sv
// Input stage that turns each new key press edge into one held event for the entry controller
`timescale 1ns/1ps

module key_capture (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 digit_press,
    input  logic [3:0]           digit,
    input  logic                 op_press,
    input  calc_pkg::op_t        op_key,
    input  logic                 equal_press,
    input  logic                 key_read,
    output logic                 key_valid,
    output calc_pkg::key_event_t key_event
);

    logic                 digit_prev;
    logic                 op_prev;
    logic                 equal_prev;
    logic                 digit_rise;
    logic                 op_rise;
    logic                 equal_rise;
    logic                 any_rise;
    calc_pkg::key_event_t new_event;

    assign digit_rise = digit_press & ~digit_prev;
    assign op_rise    = op_press & ~op_prev;
    assign equal_rise = equal_press & ~equal_prev;
    assign any_rise   = digit_rise | op_rise | equal_rise;

    // Equal wins over an operator, an operator over a digit
    always_comb begin
        new_event.kind  = calc_pkg::KEY_DIGIT;
        new_event.digit = digit;
        new_event.op    = calc_pkg::OP_NONE;
        if (equal_rise) begin
            new_event.kind  = calc_pkg::KEY_EQUAL;
            new_event.digit = 4'd0;
        end else if (op_rise) begin
            new_event.kind  = calc_pkg::KEY_OP;
            new_event.digit = 4'd0;
            new_event.op    = op_key;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            digit_prev <= 1'b0;
            op_prev    <= 1'b0;
            equal_prev <= 1'b0;
            key_valid  <= 1'b0;
        end else begin
            digit_prev <= digit_press;
            op_prev    <= op_press;
            equal_prev <= equal_press;
            if (key_valid) begin
                // Held until the controller acks, new edges are lost meanwhile
                if (key_read) begin
                    key_valid <= 1'b0;
                end
            end else if (any_rise) begin
                key_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!key_valid && any_rise) begin
            key_event <= new_event;
        end
    end

endmodule

// File: logic/entry_control.sv
// Entry controller that builds two operands from key events and runs the arithmetic units
`timescale 1ns/1ps

module entry_control #(
    parameter int WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 key_valid,
    input  calc_pkg::key_event_t key_event,
    output logic                 key_read,
    output logic [WIDTH-1:0]     a_in,
    output logic [WIDTH-1:0]     b_in,
    output logic                 sub,
    output logic                 add_start,
    input  logic                 add_finish,
    input  logic [WIDTH-1:0]     add_out,
    output logic [WIDTH-1:0]     m_in1,
    output logic [WIDTH-1:0]     m_in2,
    output logic                 mul_start,
    input  logic                 mul_finish,
    input  logic [WIDTH-1:0]     mul_out,
    output logic [WIDTH-1:0]     display,
    output logic                 complete
);

    localparam int MAG_W = WIDTH - 1;

    calc_pkg::ctrl_state_t state;
    calc_pkg::ctrl_state_t next_state;
    calc_pkg::op_t         op_latched;
    logic [WIDTH-1:0]      operand1;
    logic [WIDTH-1:0]      operand2;
    logic [3:0]            digit_latched;
    logic                  in_entry;
    logic                  take_key;
    logic                  is_digit;
    logic                  is_neg;
    logic                  is_oper;
    logic                  is_equal;

    assign in_entry = (state == calc_pkg::WAIT_OP1) || (state == calc_pkg::WAIT_OP2);

    // The cycle after a take, key_valid is still up while key_read clears it
    assign take_key = in_entry & key_valid & ~key_read;
    assign is_digit = take_key && (key_event.kind == calc_pkg::KEY_DIGIT);
    assign is_neg   = take_key && (key_event.kind == calc_pkg::KEY_OP)
                      && (key_event.op == calc_pkg::OP_NEG);
    assign is_oper  = take_key && (key_event.kind == calc_pkg::KEY_OP)
                      && (key_event.op != calc_pkg::OP_NEG)
                      && (key_event.op != calc_pkg::OP_NONE);
    assign is_equal = take_key && (key_event.kind == calc_pkg::KEY_EQUAL);

    always_comb begin
        next_state = state;
        case (state)
            calc_pkg::WAIT_OP1: begin
                if (is_digit) begin
                    next_state = calc_pkg::MULT_OP1;
                end else if (is_oper) begin
                    next_state = calc_pkg::WAIT_OP2;
                end
            end
            calc_pkg::MULT_OP1: begin
                if (mul_finish) begin
                    next_state = calc_pkg::ADD_DIGIT_OP1;
                end
            end
            calc_pkg::ADD_DIGIT_OP1: next_state = calc_pkg::WAIT_OP1;
            calc_pkg::WAIT_OP2: begin
                if (is_digit) begin
                    next_state = calc_pkg::MULT_OP2;
                end else if (is_equal) begin
                    next_state = calc_pkg::SEND_COMPUTE;
                end
            end
            calc_pkg::MULT_OP2: begin
                if (mul_finish) begin
                    next_state = calc_pkg::ADD_DIGIT_OP2;
                end
            end
            calc_pkg::ADD_DIGIT_OP2: next_state = calc_pkg::WAIT_OP2;
            // Start strobe is high during this state
            calc_pkg::SEND_COMPUTE:  next_state = calc_pkg::WAIT_COMPUTE;
            calc_pkg::WAIT_COMPUTE: begin
                if (add_finish || mul_finish) begin
                    next_state = calc_pkg::SHOW_RESULT;
                end
            end
            calc_pkg::SHOW_RESULT:   next_state = calc_pkg::WAIT_OP1;
            default:                 next_state = calc_pkg::WAIT_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= calc_pkg::WAIT_OP1;
            key_read   <= 1'b0;
            add_start  <= 1'b0;
            mul_start  <= 1'b0;
            complete   <= 1'b0;
            display    <= '0;
            operand1   <= '0;
            operand2   <= '0;
            op_latched <= calc_pkg::OP_NONE;
        end else begin
            state     <= next_state;
            key_read  <= take_key;
            add_start <= 1'b0;
            mul_start <= 1'b0;
            complete  <= 1'b0;
            case (state)
                calc_pkg::WAIT_OP1: begin
                    if (is_digit) begin
                        mul_start <= 1'b1;
                    end else if (is_neg) begin
                        operand1[WIDTH-1] <= ~operand1[WIDTH-1];
                    end else if (is_oper) begin
                        op_latched <= key_event.op;
                    end
                end
                calc_pkg::MULT_OP1: begin
                    // Keep own sign so a leading negate survives a zero product
                    if (mul_finish) begin
                        operand1 <= {operand1[WIDTH-1], mul_out[MAG_W-1:0]};
                    end
                end
                calc_pkg::ADD_DIGIT_OP1: begin
                    operand1[MAG_W-1:0] <= operand1[MAG_W-1:0] + MAG_W'(digit_latched);
                end
                calc_pkg::WAIT_OP2: begin
                    if (is_digit) begin
                        mul_start <= 1'b1;
                    end else if (is_neg) begin
                        operand2[WIDTH-1] <= ~operand2[WIDTH-1];
                    end else if (is_equal) begin
                        if (op_latched == calc_pkg::OP_MUL) begin
                            mul_start <= 1'b1;
                        end else begin
                            add_start <= 1'b1;
                        end
                    end
                end
                calc_pkg::MULT_OP2: begin
                    if (mul_finish) begin
                        operand2 <= {operand2[WIDTH-1], mul_out[MAG_W-1:0]};
                    end
                end
                calc_pkg::ADD_DIGIT_OP2: begin
                    operand2[MAG_W-1:0] <= operand2[MAG_W-1:0] + MAG_W'(digit_latched);
                end
                calc_pkg::WAIT_COMPUTE: begin
                    // Result lands together with complete in SHOW_RESULT
                    if (add_finish) begin
                        display  <= add_out;
                        complete <= 1'b1;
                    end else if (mul_finish) begin
                        display  <= mul_out;
                        complete <= 1'b1;
                    end
                end
                calc_pkg::SHOW_RESULT: begin
                    operand1 <= '0;
                    operand2 <= '0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (is_digit) begin
            digit_latched <= key_event.digit;
            m_in1         <= (state == calc_pkg::WAIT_OP1) ? operand1 : operand2;
            m_in2         <= WIDTH'(10);
        end
        if (is_equal && state == calc_pkg::WAIT_OP2) begin
            a_in  <= operand1;
            b_in  <= operand2;
            sub   <= (op_latched == calc_pkg::OP_SUB);
            m_in1 <= operand1;
            m_in2 <= operand2;
        end
    end

endmodule

// File: logic/addsub_unit.sv
// Sign-magnitude adder/subtractor, result registered one cycle after its start pulse
`timescale 1ns/1ps

module addsub_unit #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic [WIDTH-1:0] a_in,
    input  logic [WIDTH-1:0] b_in,
    input  logic             sub,
    input  logic             add_start,
    output logic [WIDTH-1:0] add_out,
    output logic             add_finish
);

    localparam int MAG_W = WIDTH - 1;

    logic             a_sign;
    logic             b_sign;
    logic [MAG_W-1:0] a_mag;
    logic [MAG_W-1:0] b_mag;
    logic             res_sign;
    logic [MAG_W-1:0] res_mag;

    assign a_sign = a_in[WIDTH-1];
    // Subtraction is addition of the negated b
    assign b_sign = b_in[WIDTH-1] ^ sub;
    assign a_mag  = a_in[MAG_W-1:0];
    assign b_mag  = b_in[MAG_W-1:0];

    always_comb begin
        if (a_sign == b_sign) begin
            res_mag  = a_mag + b_mag;
            res_sign = a_sign;
        end else if (a_mag >= b_mag) begin
            res_mag  = a_mag - b_mag;
            res_sign = a_sign;
        end else begin
            res_mag  = b_mag - a_mag;
            res_sign = b_sign;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            add_finish <= 1'b0;
        end else begin
            add_finish <= add_start;
        end
    end

    // Zero always comes out positive
    always_ff @(posedge clk) begin
        if (add_start) begin
            add_out <= {res_sign & (res_mag != '0), res_mag};
        end
    end

endmodule

// File: logic/shift_multiplier.sv
// Sequential shift-and-add sign-magnitude multiplier shared by digit entry and the multiply key
`timescale 1ns/1ps

module shift_multiplier #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic [WIDTH-1:0] m_in1,
    input  logic [WIDTH-1:0] m_in2,
    input  logic             mul_start,
    output logic [WIDTH-1:0] mul_out,
    output logic             mul_finish
);

    localparam int MAG_W = WIDTH - 1;
    localparam int CNT_W = $clog2(WIDTH);

    logic [MAG_W-1:0] acc;
    logic [MAG_W-1:0] mcand;
    logic [MAG_W-1:0] mplier;
    logic [MAG_W-1:0] first_part;
    logic             prod_sign;
    logic             busy;
    logic [CNT_W-1:0] count;

    // Bit 0 is folded into the load so finish lands WIDTH-1 cycles after start
    assign first_part = m_in2[0] ? m_in1[MAG_W-1:0] : '0;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy       <= 1'b0;
            count      <= '0;
            mul_finish <= 1'b0;
        end else begin
            mul_finish <= 1'b0;
            if (mul_start) begin
                busy  <= 1'b1;
                count <= CNT_W'(1);
            end else if (busy) begin
                count <= count + 1'b1;
                // Last magnitude bit is taken this cycle
                if (count == CNT_W'(MAG_W - 1)) begin
                    busy       <= 1'b0;
                    mul_finish <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            acc       <= first_part;
            mcand     <= m_in1[MAG_W-1:0] << 1;
            mplier    <= m_in2[MAG_W-1:0] >> 1;
            prod_sign <= m_in1[WIDTH-1] ^ m_in2[WIDTH-1];
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Magnitude wraps naturally at MAG_W bits, zero forced positive
    assign mul_out = {prod_sign & (acc != '0), acc};

endmodule

// File: logic/calculator_top.sv
// Top level of the keypad calculator, wires key capture, controller and arithmetic units
`timescale 1ns/1ps

module calculator_top #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             digit_press,
    input  logic [3:0]       digit,
    input  logic             op_press,
    input  calc_pkg::op_t    op_key,
    input  logic             equal_press,
    output logic [WIDTH-1:0] display,
    output logic             complete
);

    logic                 key_valid;
    logic                 key_read;
    calc_pkg::key_event_t key_event;
    logic [WIDTH-1:0]     a_in;
    logic [WIDTH-1:0]     b_in;
    logic                 sub;
    logic                 add_start;
    logic                 add_finish;
    logic [WIDTH-1:0]     add_out;
    logic [WIDTH-1:0]     m_in1;
    logic [WIDTH-1:0]     m_in2;
    logic                 mul_start;
    logic                 mul_finish;
    logic [WIDTH-1:0]     mul_out;

    key_capture u_key_capture (
        .clk         (clk),
        .nRST        (nRST),
        .digit_press (digit_press),
        .digit       (digit),
        .op_press    (op_press),
        .op_key      (op_key),
        .equal_press (equal_press),
        .key_read    (key_read),
        .key_valid   (key_valid),
        .key_event   (key_event)
    );

    entry_control #(.WIDTH(WIDTH)) u_entry_control (
        .clk        (clk),
        .nRST       (nRST),
        .key_valid  (key_valid),
        .key_event  (key_event),
        .key_read   (key_read),
        .a_in       (a_in),
        .b_in       (b_in),
        .sub        (sub),
        .add_start  (add_start),
        .add_finish (add_finish),
        .add_out    (add_out),
        .m_in1      (m_in1),
        .m_in2      (m_in2),
        .mul_start  (mul_start),
        .mul_finish (mul_finish),
        .mul_out    (mul_out),
        .display    (display),
        .complete   (complete)
    );

    addsub_unit #(.WIDTH(WIDTH)) u_addsub_unit (
        .clk        (clk),
        .nRST       (nRST),
        .a_in       (a_in),
        .b_in       (b_in),
        .sub        (sub),
        .add_start  (add_start),
        .add_out    (add_out),
        .add_finish (add_finish)
    );

    shift_multiplier #(.WIDTH(WIDTH)) u_shift_multiplier (
        .clk        (clk),
        .nRST       (nRST),
        .m_in1      (m_in1),
        .m_in2      (m_in2),
        .mul_start  (mul_start),
        .mul_out    (mul_out),
        .mul_finish (mul_finish)
    );

endmodule

// File: sim/calculator_assertions.sv
// Strobe and timing checks on the entry controller, attached to entry_control with bind
`timescale 1ns/1ps

module calculator_assertions (
    input logic                  clk,
    input logic                  nRST,
    input logic                  key_valid,
    input logic                  key_read,
    input logic                  add_start,
    input logic                  add_finish,
    input logic                  mul_start,
    input logic                  mul_finish,
    input logic                  complete,
    input calc_pkg::ctrl_state_t state
);

    int unsigned fail_count = 0;
    logic        mul_busy;

    // Multiplier busy from its start until its finish pulse
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            mul_busy <= 1'b0;
        end else if (mul_start) begin
            mul_busy <= 1'b1;
        end else if (mul_finish) begin
            mul_busy <= 1'b0;
        end
    end

    complete_single: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
        else begin
            $error("complete stayed high for more than one cycle");
            fail_count++;
        end

    complete_in_show: assert property (@(posedge clk) disable iff (!nRST)
        complete |-> state == calc_pkg::SHOW_RESULT)
        else begin
            $error("complete pulsed outside SHOW_RESULT");
            fail_count++;
        end

    add_finish_next: assert property (@(posedge clk) disable iff (!nRST)
        add_start |=> add_finish)
        else begin
            $error("add_finish did not follow add_start by one cycle");
            fail_count++;
        end

    mul_start_idle: assert property (@(posedge clk) disable iff (!nRST)
        mul_start |-> !mul_busy)
        else begin
            $error("mul_start issued while the multiplier was busy");
            fail_count++;
        end

    key_read_valid: assert property (@(posedge clk) disable iff (!nRST)
        key_read |-> key_valid)
        else begin
            $error("key_read asserted with no key pending");
            fail_count++;
        end

endmodule

bind entry_control calculator_assertions u_assertions (
    .clk        (clk),
    .nRST       (nRST),
    .key_valid  (key_valid),
    .key_read   (key_read),
    .add_start  (add_start),
    .add_finish (add_finish),
    .mul_start  (mul_start),
    .mul_finish (mul_finish),
    .complete   (complete),
    .state      (state)
);

// File: sim/calculator_tb.sv
// Testbench for the keypad calculator, keys in operand sequences and checks each result
`timescale 1ns/1ps

module calculator_tb;

    localparam int WIDTH      = 16;
    localparam int MAG_W      = WIDTH - 1;
    localparam int CLK_PERIOD = 10;
    localparam int DIGIT_CYC  = WIDTH + 4;
    localparam int RAND_PAIRS = 20;
    localparam int NUM_TESTS  = 10 + 3 * RAND_PAIRS;

    logic             clk;
    logic             nRST;
    logic             digit_press;
    logic [3:0]       digit;
    logic             op_press;
    calc_pkg::op_t    op_key;
    logic             equal_press;
    logic [WIDTH-1:0] display;
    logic             complete;

    int               errors = 0;
    int               keys_sent = 0;
    int               reads_seen = 0;
    int               equals_sent = 0;
    int               completes_seen = 0;
    integer           seed;
    string            test_name;
    logic [WIDTH-1:0] expected;

    calculator_top #(.WIDTH(WIDTH)) dut (
        .clk         (clk),
        .nRST        (nRST),
        .digit_press (digit_press),
        .digit       (digit),
        .op_press    (op_press),
        .op_key      (op_key),
        .equal_press (equal_press),
        .display     (display),
        .complete    (complete)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 40 * DIGIT_CYC * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    // Key acks and results, with every complete checked against the model
    always @(posedge clk) begin
        if (dut.key_read) begin
            reads_seen <= reads_seen + 1;
        end
        if (complete) begin
            completes_seen <= completes_seen + 1;
            assert (completes_seen < equals_sent) else begin
                $display("complete pulsed in test %s with no equal key pending", test_name);
                errors++;
            end
            assert (display === expected) else begin
                $display("[FAIL] %s: expected %h, actual %h", test_name, expected, display);
                errors++;
            end
        end
    end

    function automatic longint signed_value(input logic [WIDTH-1:0] x);
        longint mag;
        mag = longint'(x[MAG_W-1:0]);
        return x[WIDTH-1] ? -mag : mag;
    endfunction

    // Magnitude wraps at MAG_W bits and zero is positive
    function automatic logic [WIDTH-1:0] to_sign_mag(input longint v);
        longint mag;
        mag = ((v < 0) ? -v : v) % (longint'(1) << MAG_W);
        return {(v < 0) && (mag != 0), mag[MAG_W-1:0]};
    endfunction

    function automatic logic [WIDTH-1:0] model_result(input logic [WIDTH-1:0] a,
                                                      input logic [WIDTH-1:0] b,
                                                      input calc_pkg::op_t op);
        case (op)
            calc_pkg::OP_SUB: return to_sign_mag(signed_value(a) - signed_value(b));
            calc_pkg::OP_MUL: return to_sign_mag(signed_value(a) * signed_value(b));
            default:          return to_sign_mag(signed_value(a) + signed_value(b));
        endcase
    endfunction

    task automatic press_key(input calc_pkg::key_kind_t kind, input logic [3:0] value,
                             input calc_pkg::op_t op);
        @(posedge clk);
        case (kind)
            calc_pkg::KEY_DIGIT: begin
                digit       <= value;
                digit_press <= 1'b1;
            end
            calc_pkg::KEY_OP: begin
                op_key   <= op;
                op_press <= 1'b1;
            end
            default: equal_press <= 1'b1;
        endcase
        repeat (2) @(posedge clk);
        digit_press <= 1'b0;
        op_press    <= 1'b0;
        equal_press <= 1'b0;
    endtask

    task automatic wait_key_read();
        int cycles;
        cycles = 0;
        while (reads_seen < keys_sent && cycles < DIGIT_CYC) begin
            @(posedge clk);
            cycles++;
        end
        if (reads_seen < keys_sent) begin
            $display("A key in test %s was not taken within %0d cycles", test_name, DIGIT_CYC);
            errors++;
            keys_sent = reads_seen;
        end
    endtask

    task automatic send_key(input calc_pkg::key_kind_t kind, input logic [3:0] value,
                            input calc_pkg::op_t op);
        keys_sent++;
        press_key(kind, value, op);
        wait_key_read();
    endtask

    // Keys one operand in and returns the value the calculator should hold
    task automatic enter_operand(input int value, input bit negate, input bit neg_first,
                                 output logic [WIDTH-1:0] operand);
        int     digits[$];
        int     rest;
        longint mag;
        rest = value;
        mag  = 0;
        do begin
            digits.push_front(rest % 10);
            rest = rest / 10;
        end while (rest > 0);
        if (negate && neg_first) begin
            send_key(calc_pkg::KEY_OP, 4'd0, calc_pkg::OP_NEG);
        end
        foreach (digits[i]) begin
            send_key(calc_pkg::KEY_DIGIT, 4'(digits[i]), calc_pkg::OP_NONE);
            mag = (mag * 10 + digits[i]) % (longint'(1) << MAG_W);
        end
        if (negate && !neg_first) begin
            send_key(calc_pkg::KEY_OP, 4'd0, calc_pkg::OP_NEG);
        end
        operand = {negate, mag[MAG_W-1:0]};
    endtask

    task automatic press_equal(input logic [WIDTH-1:0] operand1,
                               input logic [WIDTH-1:0] operand2, input calc_pkg::op_t op);
        int cycles;
        expected = model_result(operand1, operand2, op);
        equals_sent++;
        send_key(calc_pkg::KEY_EQUAL, 4'd0, calc_pkg::OP_NONE);
        cycles = 0;
        while (completes_seen < equals_sent && cycles < 2 * WIDTH + 8) begin
            @(posedge clk);
            cycles++;
        end
        if (completes_seen < equals_sent) begin
            $display("No complete pulse after the equal key in test %s", test_name);
            errors++;
            equals_sent = completes_seen;
        end
    endtask

    task automatic run_test(input string name, input int value1, input bit neg1,
                            input calc_pkg::op_t op, input int value2, input bit neg2,
                            input bit neg_first);
        logic [WIDTH-1:0] operand1;
        logic [WIDTH-1:0] operand2;
        test_name = name;
        enter_operand(value1, neg1, neg_first, operand1);
        send_key(calc_pkg::KEY_OP, 4'd0, op);
        enter_operand(value2, neg2, neg_first, operand2);
        press_equal(operand1, operand2, op);
    endtask

    initial begin
        calc_pkg::op_t rand_ops[3];
        int            k;
        int            i;
        int            value1;
        int            value2;
        bit            neg1;
        bit            neg2;
        int            assert_fails;
        nRST        = 1'b0;
        digit_press = 1'b0;
        digit       = 4'd0;
        op_press    = 1'b0;
        op_key      = calc_pkg::OP_NONE;
        equal_press = 1'b0;
        seed        = 32'hb95a;
        test_name   = "reset";
        expected    = '0;
        rand_ops    = '{calc_pkg::OP_ADD, calc_pkg::OP_SUB, calc_pkg::OP_MUL};
        repeat (5) @(posedge clk);
        nRST <= 1'b1;
        @(posedge clk);
        assert (display === '0) else begin
            $display("[FAIL] reset_display: expected %h, actual %h", {WIDTH{1'b0}}, display);
            errors++;
        end

        run_test("add_multi_digit", 123, 1'b0, calc_pkg::OP_ADD, 4567, 1'b0, 1'b0);
        run_test("add_wrap", 30000, 1'b0, calc_pkg::OP_ADD, 5000, 1'b0, 1'b0);
        run_test("sub_negative", 25, 1'b0, calc_pkg::OP_SUB, 300, 1'b0, 1'b0);
        run_test("sub_equal_zero", 77, 1'b0, calc_pkg::OP_SUB, 77, 1'b0, 1'b0);
        run_test("mul_product", 123, 1'b0, calc_pkg::OP_MUL, 45, 1'b0, 1'b0);
        run_test("mul_wrap", 500, 1'b0, calc_pkg::OP_MUL, 300, 1'b0, 1'b0);
        run_test("neg_first_mul", 12, 1'b1, calc_pkg::OP_MUL, 7, 1'b0, 1'b1);
        run_test("neg_both_sub", 40, 1'b1, calc_pkg::OP_SUB, 15, 1'b1, 1'b1);
        run_test("neg_zero_add", 0, 1'b1, calc_pkg::OP_ADD, 0, 1'b1, 1'b0);

        // The 7 lands while the 4 is still held, so 34 + 5 is expected
        test_name = "drop_pending_press";
        send_key(calc_pkg::KEY_DIGIT, 4'd3, calc_pkg::OP_NONE);
        keys_sent++;
        press_key(calc_pkg::KEY_DIGIT, 4'd4, calc_pkg::OP_NONE);
        press_key(calc_pkg::KEY_DIGIT, 4'd7, calc_pkg::OP_NONE);
        wait_key_read();
        send_key(calc_pkg::KEY_OP, 4'd0, calc_pkg::OP_ADD);
        send_key(calc_pkg::KEY_DIGIT, 4'd5, calc_pkg::OP_NONE);
        press_equal({1'b0, 15'd34}, {1'b0, 15'd5}, calc_pkg::OP_ADD);

        for (k = 0; k < 3; k++) begin
            for (i = 0; i < RAND_PAIRS; i++) begin
                value1 = $unsigned($random(seed)) % 100000;
                value2 = $unsigned($random(seed)) % 10000;
                neg1   = ($random(seed) & 1) != 0;
                neg2   = ($random(seed) & 1) != 0;
                run_test($sformatf("random_%s_%0d", rand_ops[k].name(), i),
                         value1, neg1, rand_ops[k], value2, neg2, i[0]);
            end
        end

        repeat (4) @(posedge clk);
        assert_fails = dut.u_entry_control.u_assertions.fail_count;
        $display("Errors: %0d check failures, %0d assertion failures", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/calc_pkg.sv
logic/key_capture.sv
logic/entry_control.sv
logic/addsub_unit.sv
logic/shift_multiplier.sv
logic/calculator_top.sv
sim/calculator_assertions.sv
sim/calculator_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module calculator_tb \
    -f sim.f -o calculator_sim \
    && ./obj_dir/calculator_sim +verilator+error+limit+1000 | tee sim.log
grep -qx '>>> PASS' sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
